//--- icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// address split of a 32-bit pc
`define ICACHE_ADDR_W     32
`define ICACHE_OFFSET_W   5                       // byte offset in a line
`define ICACHE_INDEX_W    8
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)
`define ICACHE_WORD_SEL_W (`ICACHE_OFFSET_W - 2)

// geometry
`define ICACHE_WORDS      (1 << `ICACHE_WORD_SEL_W)  // words per line
`define ICACHE_SETS       (1 << `ICACHE_INDEX_W)
`define ICACHE_WAYS       2                        // one lru bit covers two ways

`define ICACHE_BURST_LEN  (`ICACHE_WORDS - 1)      // arlen of a line fill
`define ICACHE_ARSIZE     3'd2                     // 4-byte beats

`endif

//--- icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef logic [31:0] word_t;                       // one instruction

    typedef logic [`ICACHE_TAG_W-1:0]      tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]    index_t;
    typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t;

    // word 0 sits in the low bits
    typedef word_t [`ICACHE_WORDS-1:0] line_t;

    // pc seen as its cache fields, msb first
    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word_sel;
        logic [1:0] byte_off;
    } fetch_addr_t;

endpackage

`default_nettype wire

//--- icache_if.sv
`timescale 1ns/1ps
`default_nettype none

// ctrl to lookup: registered address and state updates
interface lookup_if;
    icache_pkg::fetch_addr_t addr;
    logic                    lru_touch;     // hit taken this cycle
    logic                    fill_en;       // line written this cycle
    logic                    hit;
    logic                    hit_way;
    logic                    victim_way;
    icache_pkg::word_t       inst0;
    icache_pkg::word_t       inst1;
    logic                    inst1_valid;

    modport ctrl (output addr, lru_touch, fill_en,
                  input  hit, hit_way, victim_way, inst0, inst1, inst1_valid);
    modport lookup (input  addr, lru_touch, fill_en,
                    output hit, hit_way, victim_way, inst0, inst1, inst1_valid);
endinterface

// ctrl to refill engine
interface refill_if;
    logic                    start;         // one-cycle pulse
    logic                    uncached;
    icache_pkg::fetch_addr_t addr;
    logic                    done;          // one-cycle pulse
    icache_pkg::line_t       line;
    logic                    single_word;

    modport ctrl (output start, uncached, addr, input done, line, single_word);
    modport refill (input start, uncached, addr, output done, line, single_word);
endinterface

`default_nettype wire

//--- icache_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire entry_t                   wr_data,
    input  wire logic                     rd_en,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output entry_t                        rd_data
);

    entry_t mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency
    // same-address read during a write returns the old entry
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_lookup (
    input  wire logic                    clk,
    input  wire logic                    rst,
    lookup_if.lookup                     lk,
    input  wire icache_pkg::tag_t        tag_rd0,
    input  wire icache_pkg::tag_t        tag_rd1,
    input  wire icache_pkg::line_t       line_rd0,
    input  wire icache_pkg::line_t       line_rd1,
    input  wire icache_pkg::line_t       fill_line,
    output logic                         rd_en,
    output icache_pkg::index_t           rd_index,
    output icache_pkg::index_t           wr_index,
    output logic [`ICACHE_WAYS-1:0]      tag_we,
    output logic [`ICACHE_WAYS-1:0]      line_we,
    output icache_pkg::tag_t             wr_tag
);

    logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] valid_q;
    logic [`ICACHE_SETS-1:0]                   lru_q;     // way to replace next

    icache_pkg::index_t      idx;
    logic [`ICACHE_WAYS-1:0] way_hit;
    logic [`ICACHE_WAYS-1:0] way_we;
    icache_pkg::line_t       way_line;
    icache_pkg::line_t       sel_line;
    icache_pkg::word_sel_t   next_sel;

    assign idx = lk.addr.index;

    assign way_hit[0] = valid_q[idx][0] & (tag_rd0 == lk.addr.tag);
    assign way_hit[1] = valid_q[idx][1] & (tag_rd1 == lk.addr.tag);

    assign lk.hit        = |way_hit;
    assign lk.hit_way    = way_hit[1];
    assign lk.victim_way = lru_q[idx];

    // hit path reads the arrays, everything else the refill line
    assign way_line = lk.hit_way ? line_rd1 : line_rd0;
    assign sel_line = lk.lru_touch ? way_line : fill_line;

    assign next_sel       = lk.addr.word_sel + 1'b1;
    assign lk.inst0       = sel_line[lk.addr.word_sel];
    assign lk.inst1       = sel_line[next_sel];
    assign lk.inst1_valid = (next_sel != '0);    // low at the last word

    // array ports
    assign rd_en    = ~lk.fill_en;               // read port idles while a set is written
    assign rd_index = idx;
    assign wr_index = idx;
    assign wr_tag   = lk.addr.tag;

    assign way_we  = {`ICACHE_WAYS{lk.fill_en}} & {lk.victim_way, ~lk.victim_way};
    assign tag_we  = way_we;
    assign line_we = way_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (lk.fill_en) begin
            valid_q[idx][lk.victim_way] <= 1'b1;
            lru_q[idx]                  <= ~lk.victim_way;
        end else if (lk.lru_touch) begin
            lru_q[idx] <= ~lk.hit_way;   // other way becomes the victim
        end
    end

endmodule

`default_nettype wire

//--- icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_refill (
    input  wire logic                      clk,
    input  wire logic                      rst,
    refill_if.refill                       rf,
    output logic [`ICACHE_ADDR_W-1:0]      araddr,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic                           arvalid,
    input  wire logic                      arready,
    input  wire icache_pkg::word_t         rdata,
    input  wire logic                      rlast,
    input  wire logic                      rvalid,
    output logic                           rready
);

    logic                    single_q;      // uncached, one beat
    logic                    data_phase;
    logic                    done_q;
    icache_pkg::word_sel_t   beat_cnt;
    icache_pkg::line_t       line_q;
    icache_pkg::fetch_addr_t ar_addr_q;
    icache_pkg::fetch_addr_t line_base;
    logic                    beat_take;

    always_comb begin
        line_base          = rf.addr;
        line_base.word_sel = '0;
        line_base.byte_off = '0;
    end

    assign beat_take = data_phase & rvalid;

    assign araddr = ar_addr_q;
    assign arlen  = single_q ? 8'd0 : 8'(`ICACHE_BURST_LEN);
    assign arsize = `ICACHE_ARSIZE;
    assign rready = data_phase;

    assign rf.done        = done_q;
    assign rf.line        = line_q;
    assign rf.single_word = single_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid    <= 1'b0;
            data_phase <= 1'b0;
            done_q     <= 1'b0;
            single_q   <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            done_q <= 1'b0;
            if (rf.start) begin
                arvalid  <= 1'b1;
                single_q <= rf.uncached;
                // uncached beat lands at its own word slot
                beat_cnt <= rf.uncached ? rf.addr.word_sel : '0;
            end else if (arvalid && arready) begin
                arvalid    <= 1'b0;
                data_phase <= 1'b1;
            end
            if (beat_take) begin
                beat_cnt <= beat_cnt + 1'b1;     // stalls through rvalid gaps
                if (rlast) begin
                    data_phase <= 1'b0;
                    done_q     <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf.start) begin
            ar_addr_q <= rf.uncached ? rf.addr : line_base;
        end
        if (beat_take) begin
            line_q[beat_cnt] <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      req_valid,
    input  wire logic [`ICACHE_ADDR_W-1:0] req_pc,
    input  wire logic                      req_uncached,
    output logic                           req_ready,
    output logic                           resp_valid,
    input  wire logic                      resp_ready,
    output icache_pkg::word_t              resp_inst0,
    output icache_pkg::word_t              resp_inst1,
    output logic                           resp_inst1_valid,
    lookup_if.ctrl                         lk,
    refill_if.ctrl                         rf
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } state_t;

    state_t                  state;
    icache_pkg::fetch_addr_t addr_q;
    logic                    uncached_q;
    logic                    rd_done;       // array outputs belong to addr_q
    logic                    start_q;
    logic                    req_take;
    logic                    hit_take;
    logic                    fill_take;

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESPOND);

    assign req_take  = req_valid & req_ready;
    assign hit_take  = (state == LOOKUP) & rd_done & lk.hit;
    assign fill_take = (state == REFILL) & rf.done;

    assign lk.addr      = addr_q;
    assign lk.lru_touch = hit_take;
    assign lk.fill_en   = fill_take & ~rf.single_word;   // uncached never allocates

    assign rf.start    = start_q;
    assign rf.uncached = uncached_q;
    assign rf.addr     = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            uncached_q <= 1'b0;
            rd_done    <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_take) begin
                        uncached_q <= req_uncached;
                        rd_done    <= 1'b0;
                        if (req_uncached) begin
                            state   <= REFILL;      // skip the arrays
                            start_q <= 1'b1;
                        end else begin
                            state <= LOOKUP;
                        end
                    end
                end
                LOOKUP: begin
                    rd_done <= 1'b1;                // first cycle reads the arrays
                    if (rd_done) begin
                        if (lk.hit) begin
                            state <= RESPOND;
                        end else begin
                            state   <= REFILL;
                            start_q <= 1'b1;
                        end
                    end
                end
                REFILL: begin
                    if (rf.done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_take) begin
            addr_q <= icache_pkg::fetch_addr_t'(req_pc);
        end
        if (hit_take || fill_take) begin
            resp_inst0       <= lk.inst0;
            resp_inst1       <= lk.inst1;
            resp_inst1_valid <= lk.inst1_valid & ~(fill_take & rf.single_word);
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    // fetch request
    input  wire logic                      req_valid,
    output logic                           req_ready,
    input  wire logic [`ICACHE_ADDR_W-1:0] req_pc,
    input  wire logic                      req_uncached,
    // fetch response
    output logic                           resp_valid,
    input  wire logic                      resp_ready,
    output logic [31:0]                    resp_inst0,
    output logic [31:0]                    resp_inst1,
    output logic                           resp_inst1_valid,
    // read address channel
    output logic [`ICACHE_ADDR_W-1:0]      araddr,
    output logic [7:0]                     arlen,
    output logic [2:0]                     arsize,
    output logic                           arvalid,
    input  wire logic                      arready,
    // read data channel
    input  wire logic [31:0]               rdata,
    input  wire logic                      rlast,
    input  wire logic                      rvalid,
    output logic                           rready
);

    lookup_if lk_if ();
    refill_if rf_if ();

    icache_pkg::tag_t        tag_rd0;
    icache_pkg::tag_t        tag_rd1;
    icache_pkg::tag_t        wr_tag;
    icache_pkg::line_t       line_rd0;
    icache_pkg::line_t       line_rd1;
    logic                    rd_en;
    icache_pkg::index_t      rd_index;
    icache_pkg::index_t      wr_index;
    logic [`ICACHE_WAYS-1:0] tag_we;
    logic [`ICACHE_WAYS-1:0] line_we;

    icache_ctrl u_ctrl (
        .clk, .rst,
        .req_valid, .req_pc, .req_uncached, .req_ready,
        .resp_valid, .resp_ready, .resp_inst0, .resp_inst1, .resp_inst1_valid,
        .lk (lk_if.ctrl),
        .rf (rf_if.ctrl)
    );

    icache_lookup u_lookup (
        .clk, .rst,
        .lk        (lk_if.lookup),
        .tag_rd0, .tag_rd1, .line_rd0, .line_rd1,
        .fill_line (rf_if.line),
        .rd_en, .rd_index, .wr_index, .tag_we, .line_we, .wr_tag
    );

    icache_refill u_refill (
        .clk, .rst,
        .rf (rf_if.refill),
        .araddr, .arlen, .arsize, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready
    );

    icache_array #(.entry_t(icache_pkg::tag_t), .DEPTH(`ICACHE_SETS)) u_tag0 (
        .clk, .we (tag_we[0]), .wr_addr (wr_index), .wr_data (wr_tag),
        .rd_en, .rd_addr (rd_index), .rd_data (tag_rd0)
    );

    icache_array #(.entry_t(icache_pkg::tag_t), .DEPTH(`ICACHE_SETS)) u_tag1 (
        .clk, .we (tag_we[1]), .wr_addr (wr_index), .wr_data (wr_tag),
        .rd_en, .rd_addr (rd_index), .rd_data (tag_rd1)
    );

    // line data written straight from the refill buffer
    icache_array #(.entry_t(icache_pkg::line_t), .DEPTH(`ICACHE_SETS)) u_line0 (
        .clk, .we (line_we[0]), .wr_addr (wr_index), .wr_data (rf_if.line),
        .rd_en, .rd_addr (rd_index), .rd_data (line_rd0)
    );

    icache_array #(.entry_t(icache_pkg::line_t), .DEPTH(`ICACHE_SETS)) u_line1 (
        .clk, .we (line_we[1]), .wr_addr (wr_index), .wr_data (rf_if.line),
        .rd_en, .rd_addr (rd_index), .rd_data (line_rd1)
    );

endmodule

`default_nettype wire

//--- icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_tb;

    localparam int N_RAND      = 200;
    localparam int N_REQ       = N_RAND + 12;     // directed fetches on top
    localparam int MISS_CYCLES = 40;              // lookup, ar delay, 8 beats with gaps, stalls
    localparam int LIMIT       = N_REQ * MISS_CYCLES * 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_pc;
    logic        req_uncached;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_inst0;
    logic [31:0] resp_inst1;
    logic        resp_inst1_valid;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;

    // expected values of the request in flight
    logic [31:0] exp_inst0;
    logic [31:0] exp_inst1;
    logic        exp_i1v;
    logic        exp_burst;                       // miss or uncached
    logic [31:0] exp_araddr;
    logic [7:0]  exp_arlen;
    int          exp_bursts = 0;
    logic        stall_en;

    // reference cache state
    logic [`ICACHE_TAG_W-1:0] ref_tag [`ICACHE_SETS][2];
    bit                       ref_valid [`ICACHE_SETS][2];
    bit                       ref_lru [`ICACHE_SETS];      // way to replace next

    // checker state
    int          cyc = 0;
    int          acc_edge = 0;
    int          ar_count = 0;
    int          bursts = 0;
    logic        resp_seen = 1'b0;
    logic        ar_wait = 1'b0;
    logic        resp_wait = 1'b0;
    logic [31:0] held_araddr;
    logic [31:0] held_inst0;
    logic [31:0] held_inst1;
    logic        held_i1v;

    icache_top dut0 (
        .clk, .rst,
        .req_valid, .req_ready, .req_pc, .req_uncached,
        .resp_valid, .resp_ready, .resp_inst0, .resp_inst1, .resp_inst1_valid,
        .araddr, .arlen, .arsize, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // memory content, xor and rotate mix of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00} ^ 32'h6a09_e667;
        a = {a[18:0], a[31:19]} ^ (a >> 7);
        return a ^ {a[7:0], a[31:8]};
    endfunction

    // {inst1_valid, inst1, inst0} for a fetch at pc
    function automatic logic [64:0] expected_pair(input logic [31:0] pc, input logic unc);
        logic last;
        last = (pc[`ICACHE_OFFSET_W-1:2] == '1);
        return {~unc & ~last, mem_word(pc + 32'd4), mem_word(pc)};
    endfunction

    // one-bit lru per set, returns hit and updates the model
    function automatic bit model_access(input logic [31:0] pc);
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] idx;
        bit                         way;
        tag = pc[31:`ICACHE_OFFSET_W + `ICACHE_INDEX_W];
        idx = pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        if (ref_valid[idx][0] && ref_tag[idx][0] == tag) begin
            ref_lru[idx] = 1'b1;
            return 1'b1;
        end
        if (ref_valid[idx][1] && ref_tag[idx][1] == tag) begin
            ref_lru[idx] = 1'b0;
            return 1'b1;
        end
        way = ref_lru[idx];
        ref_tag[idx][way]   = tag;
        ref_valid[idx][way] = 1'b1;
        ref_lru[idx]        = !way;
        return 1'b0;
    endfunction

    task automatic fetch(input logic [31:0] pc, input logic unc);
        logic done;
        {exp_i1v, exp_inst1, exp_inst0} = expected_pair(pc, unc);
        if (unc) begin
            exp_burst = 1'b1;                     // never allocates
        end else begin
            exp_burst = !model_access(pc);
        end
        exp_araddr = unc ? pc : {pc[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        exp_arlen  = unc ? 8'd0 : 8'd7;
        if (exp_burst) begin
            exp_bursts++;
        end
        req_pc       = pc;
        req_uncached = unc;
        req_valid    = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1 req_valid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = resp_valid && resp_ready;
            @(posedge clk);
            #1 resp_ready = !stall_en || ($urandom % 3 != 0);
        end
    endtask

    initial begin : memory_model
        logic [31:0] base;
        int          len;
        int          beat;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (arvalid) begin
                repeat ($urandom % 4) @(posedge clk);
                @(posedge clk);
                #1 arready = 1'b1;
                @(negedge clk);
                base = {araddr[31:2], 2'b00};
                len  = int'(arlen);
                @(posedge clk);
                #1 arready = 1'b0;
                beat = 0;
                while (beat <= len) begin
                    if ($urandom % 4 == 0) begin
                        rvalid = 1'b0;            // gap
                    end else begin
                        rvalid = 1'b1;
                        rdata  = mem_word(base + 32'(4 * beat));
                        rlast  = (beat == len);
                    end
                    @(posedge clk);
                    #1;
                    if (rvalid) beat++;
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) abort_run($sformatf("timeout: run not finished after %0d cycles", LIMIT));
    end

    // handshakes sampled mid-cycle, where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (req_valid && req_ready) begin
                acc_edge  = cyc + 1;
                ar_count  = 0;
                resp_seen = 1'b0;
            end
            if (ar_wait) begin
                assert (arvalid && araddr == held_araddr)
                    else abort_run("arvalid or araddr changed before arready");
            end
            ar_wait     = arvalid && !arready;
            held_araddr = araddr;
            if (arvalid && arready) begin
                assert (exp_burst && ar_count == 0)
                    else abort_run("read burst issued where none was expected");
                assert (araddr == exp_araddr)
                    else abort_run($sformatf("error: araddr = %h, expected %h", araddr, exp_araddr));
                assert (arlen == exp_arlen)
                    else abort_run($sformatf("error: arlen = %h, expected %h", arlen, exp_arlen));
                assert (arsize == 3'd2)
                    else abort_run($sformatf("error: arsize = %h, expected 2", arsize));
                ar_count++;
                bursts++;
            end
            if (rvalid) begin
                assert (rready) else abort_run("read beat offered while rready was low");
            end
            if (resp_wait) begin
                assert (resp_valid && resp_inst0 == held_inst0 && resp_inst1 == held_inst1
                        && resp_inst1_valid == held_i1v)
                    else abort_run("response dropped or changed under back-pressure");
            end
            resp_wait  = resp_valid && !resp_ready;
            held_inst0 = resp_inst0;
            held_inst1 = resp_inst1;
            held_i1v   = resp_inst1_valid;
            if (resp_valid) begin
                assert (!req_ready) else abort_run("req_ready high while a response waits");
                if (!resp_seen && !exp_burst) begin
                    assert (cyc - acc_edge == 2)
                        else abort_run($sformatf("hit answered %0d cycles after acceptance",
                                                 cyc - acc_edge));
                end
                resp_seen = 1'b1;
            end
            if (resp_valid && resp_ready) begin
                assert (ar_count == (exp_burst ? 1 : 0))
                    else abort_run("response without the expected read burst");
                assert (resp_inst0 == exp_inst0)
                    else abort_run($sformatf("error: resp_inst0 = %h, expected %h",
                                             resp_inst0, exp_inst0));
                assert (resp_inst1_valid == exp_i1v)
                    else abort_run($sformatf("error: resp_inst1_valid = %h, expected %h",
                                             resp_inst1_valid, exp_i1v));
                if (exp_i1v) begin
                    assert (resp_inst1 == exp_inst1)
                        else abort_run($sformatf("error: resp_inst1 = %h, expected %h",
                                                 resp_inst1, exp_inst1));
                end
            end
        end
    end

    initial begin
        logic [31:0] pc;
        logic        unc;
        void'($urandom(32'hd14e_e1a1));
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_pc       = '0;
        req_uncached = 1'b0;
        resp_ready   = 1'b1;
        stall_en     = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        assert (req_ready && !resp_valid && !arvalid && !rready)
            else abort_run("outputs not in their idle state after reset");
        @(posedge clk);
        #1;
        fetch(32'h0000_1008, 1'b0);               // cold miss
        fetch(32'h0000_1010, 1'b0);               // same line, hit
        // tags A, B, A, C on set 2, then A hits and B misses
        fetch(32'h0001_0040, 1'b0);
        fetch(32'h0002_0040, 1'b0);
        fetch(32'h0001_0040, 1'b0);
        fetch(32'h0003_0040, 1'b0);
        fetch(32'h0001_0040, 1'b0);
        fetch(32'h0002_0040, 1'b0);
        fetch(32'h0000_2014, 1'b1);               // uncached, no allocation
        fetch(32'h0000_2014, 1'b0);
        fetch(32'h0000_301c, 1'b0);               // last word, miss path
        fetch(32'h0000_301c, 1'b0);               // and hit path
        stall_en = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            pc  = 32'h0010_0000 | (($urandom % 4) << 13) | (($urandom % 4) << 5)
                | (($urandom % 8) << 2);
            unc = ($urandom % 8 == 0);
            fetch(pc, unc);
        end
        assert (bursts == exp_bursts)
            else abort_run($sformatf("error: burst count = %h, expected %h", bursts, exp_bursts));
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
+incdir+.
icache_pkg.sv
icache_if.sv
icache_array.sv
icache_lookup.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the icache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module icache_tb \
    -f icache.f -o icache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
